// File: alu.sv
`default_nettype none

module alu (
  input  mrv_pkg::word_t    a,           // rs1 value
  input  mrv_pkg::word_t    b,           // rs2 value or imm
  input  mrv_pkg::word_t    pc,          // Present address
  input  mrv_pkg::alu_op_e  alu_op,
  input  mrv_pkg::ex_kind_e kind,
  input  logic              compressed,  // 16-bit instr, pc step of 2
  input  mrv_pkg::csr_op_e  csr_op,
  input  mrv_pkg::word_t    csr_in,      // Current CSR value
  output mrv_pkg::word_t    res,         // rd result
  output mrv_pkg::word_t    csr_res      // New CSR value
);

  mrv_pkg::word_t s;        // Raw ALU result
  mrv_pkg::word_t pc_incr;  // Link step
  logic           lt;       // rs1 below operand b
  logic [4:0]     shamt;    // Low bits of b only

  assign shamt   = b[4:0];
  assign lt      = (a < b);  // Unsigned compare
  assign pc_incr = compressed ? mrv_pkg::word_t'(2) : mrv_pkg::word_t'(4);

  //////////////////////////////////////////////////
  // Integer functions
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      mrv_pkg::alu_add: s = a + b;
      mrv_pkg::alu_sub: s = a - b;
      mrv_pkg::alu_and: s = a & b;
      mrv_pkg::alu_or:  s = a | b;
      mrv_pkg::alu_xor: s = a ^ b;
      mrv_pkg::alu_sll: s = a << shamt;
      mrv_pkg::alu_srl: s = a >> shamt;
      mrv_pkg::alu_sra: s = $signed(a) >>> shamt;  // Sign fill
      default:          s = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // CSR modify
  //////////////////////////////////////////////////

  // Register forms mask with rs1, immediate forms with imm on b
  always_comb begin
    case (csr_op)
      mrv_pkg::csr_write:     csr_res = a;
      mrv_pkg::csr_set:       csr_res = csr_in | a;
      mrv_pkg::csr_clear:     csr_res = csr_in & ~a;  // RISC-V clear
      mrv_pkg::csr_write_imm: csr_res = b;
      mrv_pkg::csr_set_imm:   csr_res = csr_in | b;
      mrv_pkg::csr_clear_imm: csr_res = csr_in & ~b;
      default:                csr_res = '0;           // Both none codes
    endcase
  end

  // Result select by kind
  always_comb begin
    case (kind)
      mrv_pkg::kind_alu:     res = s;
      mrv_pkg::kind_compare: res = lt ? mrv_pkg::word_t'(1) : s;
      mrv_pkg::kind_lui:     res = b;
      mrv_pkg::kind_auipc:   res = b + pc;       // Full pc
      mrv_pkg::kind_jal:     res = pc + pc_incr;  // Return address
      mrv_pkg::kind_csr:     res = csr_in;       // Old value to rd
      default:               res = s;
    endcase
  end

endmodule

`default_nettype wire

// File: csr_file.sv
`include "mrv_config.svh"
`default_nettype none

module csr_file (
  input  logic              clk,
  input  logic              rst_n,
  input  mrv_pkg::csr_idx_t idx,    // Shared read and write select
  output mrv_pkg::word_t    rdata,  // Combinational
  input  logic              we,
  input  mrv_pkg::word_t    wdata
);

  mrv_pkg::word_t csrs [`MRV_NUM_CSRS];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Read-modify-write happens within one cycle:
  // old value out on rdata, new value taken at the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MRV_NUM_CSRS; i++) begin
        csrs[i] <= '0;
      end
    end else if (we) begin
      csrs[idx] <= wdata;  // Written even for a zero mask
    end
  end

  // Read path
  assign rdata = csrs[idx];

endmodule

`default_nettype wire

// File: ex_core.sv
`default_nettype none

module ex_core (
  input  logic            clk,
  input  logic            rst_n,
  input  mrv_pkg::ex_op_t op,  // One op per cycle at most
  output mrv_pkg::wb_t    wb   // Must be taken every cycle
);

  // Register file link
  mrv_pkg::reg_idx_t rs1;
  mrv_pkg::reg_idx_t rs2;
  mrv_pkg::word_t    rs1_data;
  mrv_pkg::word_t    rs2_data;
  logic              rf_we;
  mrv_pkg::reg_idx_t rf_rd;
  mrv_pkg::word_t    rf_wdata;

  // CSR file link
  mrv_pkg::csr_idx_t csr_idx;
  mrv_pkg::word_t    csr_rdata;
  logic              csr_we;
  mrv_pkg::word_t    csr_wdata;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .wdata    (rf_wdata)
  );

  csr_file u_csr_file (
    .clk   (clk),
    .rst_n (rst_n),
    .idx   (csr_idx),
    .rdata (csr_rdata),
    .we    (csr_we),
    .wdata (csr_wdata)
  );

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  ex_stage u_ex_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .op        (op),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .csr_idx   (csr_idx),
    .csr_rdata (csr_rdata),
    .rf_we     (rf_we),
    .rf_rd     (rf_rd),
    .rf_wdata  (rf_wdata),
    .csr_we    (csr_we),
    .csr_wdata (csr_wdata),
    .wb        (wb)
  );

endmodule

`default_nettype wire

// File: ex_core_assert.sv
`default_nettype none

module ex_core_assert (
  input logic              clk,
  input logic              rst_n,
  input mrv_pkg::ex_op_t   op,
  input mrv_pkg::wb_t      wb,
  input logic              csr_we,     // Internal CSR write strobe
  input mrv_pkg::csr_idx_t csr_idx,
  input mrv_pkg::word_t    csr_rdata,
  input mrv_pkg::word_t    csr_wdata
);
  timeunit 1ns;
  timeprecision 1ps;

  // No writeback while reset is held
  wb_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !wb.valid)
    else $error("wb.valid high during reset");

  // Exactly one cycle from issue to writeback
  wb_follows_op: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (wb.valid == $past(op.valid)))
    else $error("wb.valid does not match op.valid of the previous cycle");

  // New CSR value readable right after the write edge
  csr_write_lands: assert property (@(posedge clk) disable iff (!rst_n)
    csr_we |=> (csr_idx != $past(csr_idx)) || (csr_rdata == $past(csr_wdata)))
    else $error("CSR write did not reach the CSR file");

endmodule

bind ex_core ex_core_assert u_ex_core_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .op        (op),
  .wb        (wb),
  .csr_we    (csr_we),
  .csr_idx   (csr_idx),
  .csr_rdata (csr_rdata),
  .csr_wdata (csr_wdata)
);

`default_nettype wire

// File: ex_core_checker.sv
`include "mrv_config.svh"
`default_nettype none

module ex_core_checker (
  input logic            clk,
  input logic            rst_n,
  input mrv_pkg::ex_op_t op,
  input mrv_pkg::wb_t    wb
);
  timeunit 1ns;
  timeprecision 1ps;

  mrv_pkg::word_t    regs [`MRV_NUM_REGS];  // x0 never written
  mrv_pkg::word_t    csrs [`MRV_NUM_CSRS];
  logic              exp_valid;             // Writeback due this cycle
  mrv_pkg::reg_idx_t exp_rd;
  mrv_pkg::word_t    exp_data;
  int                errors   = 0;
  int                ops_seen = 0;
  int                checked  = 0;          // Expected writebacks judged

  // Integer functions as the ISA defines them
  function automatic mrv_pkg::word_t alu_value(input mrv_pkg::alu_op_e f,
                                               input mrv_pkg::word_t   a,
                                               input mrv_pkg::word_t   b);
    logic [4:0] sh;
    sh = b[4:0];  // Upper bits of b ignored
    case (f)
      mrv_pkg::alu_add: return a + b;
      mrv_pkg::alu_sub: return a - b;
      mrv_pkg::alu_and: return a & b;
      mrv_pkg::alu_or:  return a | b;
      mrv_pkg::alu_xor: return a ^ b;
      mrv_pkg::alu_sll: return a << sh;
      mrv_pkg::alu_srl: return a >> sh;
      default:          return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));  // sra
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Reference model stepped at the issue edge
  //////////////////////////////////////////////////

  always @(posedge clk) begin : model_step
    mrv_pkg::word_t a;
    mrv_pkg::word_t b;
    mrv_pkg::word_t mask;
    mrv_pkg::word_t res;
    if (!rst_n) begin
      for (int i = 0; i < `MRV_NUM_REGS; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < `MRV_NUM_CSRS; i++) begin
        csrs[i] = '0;
      end
      exp_valid = 1'b0;
    end else begin
      exp_valid = op.valid;
      if (op.valid) begin
        a = regs[op.rs1];
        // Operand b from imm or rs2
        if (op.use_imm) begin
          b = op.imm;
        end else begin
          b = regs[op.rs2];
        end
        case (op.kind)
          mrv_pkg::kind_compare: res = (a < b) ? 32'd1 : alu_value(op.alu_op, a, b);
          mrv_pkg::kind_lui:     res = op.imm;
          mrv_pkg::kind_auipc:   res = op.pc + op.imm;
          mrv_pkg::kind_jal:     res = op.pc + (op.compressed ? 32'd2 : 32'd4);
          mrv_pkg::kind_csr:     res = csrs[op.csr_idx];  // Old value
          default:               res = alu_value(op.alu_op, a, b);
        endcase
        mask = op.csr_op[2] ? op.imm : a;
        if (op.kind == mrv_pkg::kind_csr) begin
          case (op.csr_op[1:0])
            2'b01:   csrs[op.csr_idx] = mask;
            2'b10:   csrs[op.csr_idx] = csrs[op.csr_idx] | mask;
            2'b11:   csrs[op.csr_idx] = csrs[op.csr_idx] & ~mask;  // Clear with inverted mask
            default: ;                                            // none keeps it
          endcase
        end
        if (op.rd != '0) begin
          regs[op.rd] = res;
        end
        exp_rd   = op.rd;
        exp_data = res;
        ops_seen++;
      end
    end
  end

  // wb is stable mid cycle
  always @(negedge clk) begin : compare_step
    if (rst_n) begin
      if (exp_valid && !wb.valid) begin
        $display("Missing writeback at %0t for an op to x%0d", $time, exp_rd);
        errors++;
      end else if (!exp_valid && wb.valid) begin
        $display("Unexpected writeback at %0t to x%0d", $time, wb.rd);
        errors++;
      end else if (exp_valid) begin
        if (wb.rd !== exp_rd) begin
          $display("Fail %0t: wb.rd is x%0d, expected x%0d", $time, wb.rd, exp_rd);
          errors++;
        end
        if (wb.data !== exp_data) begin
          $display("Fail %0t: wb.data for x%0d is %h, expected %h",
                   $time, exp_rd, wb.data, exp_data);
          errors++;
        end
      end
      if (exp_valid) begin
        checked++;
      end
    end
  end

endmodule

`default_nettype wire

// File: ex_stage.sv
`default_nettype none

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  mrv_pkg::ex_op_t   op,         // Issued operation
  // Register file read
  output mrv_pkg::reg_idx_t rs1,
  output mrv_pkg::reg_idx_t rs2,
  input  mrv_pkg::word_t    rs1_data,
  input  mrv_pkg::word_t    rs2_data,
  // CSR file read
  output mrv_pkg::csr_idx_t csr_idx,
  input  mrv_pkg::word_t    csr_rdata,
  // Register file write
  output logic              rf_we,
  output mrv_pkg::reg_idx_t rf_rd,
  output mrv_pkg::word_t    rf_wdata,
  // CSR file write
  output logic              csr_we,
  output mrv_pkg::word_t    csr_wdata,
  // Registered writeback
  output mrv_pkg::wb_t      wb
);

  logic              b_is_imm;   // Operand b source
  mrv_pkg::word_t    opb;
  mrv_pkg::word_t    alu_res;
  logic              csr_op_real;  // Code other than none
  logic              wb_valid_q;
  mrv_pkg::reg_idx_t wb_rd_q;
  mrv_pkg::word_t    wb_data_q;

  //////////////////////////////////////////////////
  // Operand select
  //////////////////////////////////////////////////

  assign rs1     = op.rs1;
  assign rs2     = op.rs2;
  assign csr_idx = op.csr_idx;

  // lui, auipc and immediate CSR forms always take imm
  assign b_is_imm = op.use_imm
                 || (op.kind == mrv_pkg::kind_lui)
                 || (op.kind == mrv_pkg::kind_auipc)
                 || ((op.kind == mrv_pkg::kind_csr) && op.csr_op[2]);

  assign opb = b_is_imm ? op.imm : rs2_data;

  alu u_alu (
    .a          (rs1_data),
    .b          (opb),
    .pc         (op.pc),
    .alu_op     (op.alu_op),
    .kind       (op.kind),
    .compressed (op.compressed),
    .csr_op     (op.csr_op),
    .csr_in     (csr_rdata),
    .res        (alu_res),
    .csr_res    (csr_wdata)
  );

  // Write strobes, x0 filtered in the register file
  assign csr_op_real = (op.csr_op[1:0] != 2'b00);
  assign rf_we       = op.valid;
  assign rf_rd       = op.rd;
  assign rf_wdata    = alu_res;
  assign csr_we      = op.valid && (op.kind == mrv_pkg::kind_csr) && csr_op_real;

  //////////////////////////////////////////////////
  // Writeback register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= op.valid;  // One cycle after issue
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= op.rd;
    wb_data_q <= alu_res;
  end

  assign wb = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q};

endmodule

`default_nettype wire

// File: mrv_config.svh
`ifndef MRV_CONFIG_SVH
`define MRV_CONFIG_SVH

`default_nettype none

//////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////

`define MRV_XLEN      32  // Data word width
`define MRV_NUM_REGS  32  // Integer registers incl. x0
`define MRV_NUM_CSRS  4   // Generic CSRs, no real addresses

// x0 is hardwired, so storage holds one less
`define MRV_NUM_STORE (`MRV_NUM_REGS - 1)

`default_nettype wire

`endif

// File: mrv_pkg.sv
`include "mrv_config.svh"
`default_nettype none

package mrv_pkg;

  typedef logic [`MRV_XLEN-1:0]              word_t;     // Data, address, imm
  typedef logic [$clog2(`MRV_NUM_REGS)-1:0]  reg_idx_t;  // x0..x31
  typedef logic [$clog2(`MRV_NUM_CSRS)-1:0]  csr_idx_t;  // Generic CSR select

  // ALU function codes
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sub = 3'b001,
    alu_and = 3'b010,
    alu_or  = 3'b011,
    alu_xor = 3'b100,
    alu_sll = 3'b101,
    alu_srl = 3'b110,
    alu_sra = 3'b111
  } alu_op_e;

  // Bit 2 picks immediate form, bits 1:0 the function
  typedef enum logic [2:0] {
    csr_none       = 3'b000,
    csr_write      = 3'b001,
    csr_set        = 3'b010,
    csr_clear      = 3'b011,
    csr_none_imm   = 3'b100,
    csr_write_imm  = 3'b101,
    csr_set_imm    = 3'b110,
    csr_clear_imm  = 3'b111
  } csr_op_e;

  // Where the rd result comes from
  typedef enum logic [2:0] {
    kind_alu     = 3'd0,
    kind_compare = 3'd1,
    kind_lui     = 3'd2,
    kind_auipc   = 3'd3,
    kind_jal     = 3'd4,  // Also jalr
    kind_csr     = 3'd5
  } ex_kind_e;

  typedef struct packed {
    logic      valid;       // Issue strobe
    ex_kind_e  kind;
    alu_op_e   alu_op;
    csr_op_e   csr_op;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    csr_idx_t  csr_idx;
    word_t     imm;
    logic      use_imm;     // Operand b from imm
    word_t     pc;
    logic      compressed;  // 16-bit instruction
  } ex_op_t;

  typedef struct packed {
    logic      valid;
    reg_idx_t  rd;
    word_t     data;
  } wb_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`include "mrv_config.svh"
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  mrv_pkg::reg_idx_t rs1,       // Read port A
  input  mrv_pkg::reg_idx_t rs2,       // Read port B
  output mrv_pkg::word_t    rs1_data,
  output mrv_pkg::word_t    rs2_data,
  input  logic              we,
  input  mrv_pkg::reg_idx_t rd,
  input  mrv_pkg::word_t    wdata
);

  // x1..x31 only
  mrv_pkg::word_t regs [1:`MRV_NUM_STORE];

  logic wr_en;  // Write past the x0 filter

  assign wr_en = we && (rd != '0);

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i <= `MRV_NUM_STORE; i++) begin
        regs[i] <= '0;  // All registers start at zero
      end
    end else if (wr_en) begin
      regs[rd] <= wdata;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Same-cycle write is not bypassed, the
  // next op sees it after the edge
  always_comb begin
    rs1_data = '0;  // x0
    if (rs1 != '0) begin
      rs1_data = regs[rs1];
    end
  end

  always_comb begin
    rs2_data = '0;
    if (rs2 != '0) begin
      rs2_data = regs[rs2];
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then judge the result from the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_ex_core -f vlog.f \
  && ./obj_dir/Vtb_ex_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Result: FAIL, no pass line in log"; exit 1; }
echo "Result: PASS"

// File: tb_ex_core.sv
`default_nettype none

module tb_ex_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_OPS     = 2000;
  localparam int DRAIN_LIMIT = 16;  // Cycles allowed for the last writeback

  logic            clk;
  logic            rst_n;
  mrv_pkg::ex_op_t op;
  mrv_pkg::wb_t    wb;
  integer          seed;
  int              issued;          // Valid ops driven so far
  int              drain;
  int              tb_errors;
  logic            mid_reset_done;

  ex_core u_ex_core (.clk(clk), .rst_n(rst_n), .op(op), .wb(wb));

  ex_core_checker u_checker (.clk(clk), .rst_n(rst_n), .op(op), .wb(wb));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Hard stop if the run stalls
  initial begin : watchdog
    #200_000;
    $display("Simulation did not finish in time");
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Idle cycle first so no writeback is in flight at the reset edge
  task automatic hold_reset();
    op = '0;
    @(negedge clk);
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Small register window so results get reused soon
  task automatic make_op(output mrv_pkg::ex_op_t o);
    logic [31:0] r;
    r            = $random(seed);
    o            = '0;
    o.valid      = 1'b1;
    o.kind       = mrv_pkg::ex_kind_e'(3'(r[15:0] % 16'd6));
    o.alu_op     = mrv_pkg::alu_op_e'(r[18:16]);
    o.csr_op     = mrv_pkg::csr_op_e'(r[21:19]);  // All eight codes
    o.rs1        = r[31] ? r[8:4] : {2'b00, r[24:22]};  // High reg read back
    o.rs2        = {2'b00, r[27:25]};
    o.rd         = r[31] ? r[8:4] : {2'b00, r[30:28]};  // Sometimes a high reg
    o.csr_idx    = r[1:0];
    o.use_imm    = r[2];
    o.compressed = r[3];
    o.imm        = $random(seed);
    if (r[9]) begin
      o.imm = o.imm & 32'h3f;  // Small masks and shifts of 32..63
    end
    o.pc         = $random(seed) & 32'hffff_fffe;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    seed           = 32'h838c;
    issued         = 0;
    tb_errors      = 0;
    mid_reset_done = 1'b0;
    op             = '0;
    rst_n          = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (issued < NUM_OPS) begin
      @(negedge clk);
      if (!mid_reset_done && issued == NUM_OPS / 2) begin
        mid_reset_done = 1'b1;
        hold_reset();  // Later reads must see zero again
      end else if (($random(seed) & 3) != 0) begin
        make_op(op);
        issued++;
      end else begin
        op = '0;       // Bubble about one cycle in four
      end
    end
    @(negedge clk);
    op    = '0;
    drain = 0;
    while (u_checker.checked < u_checker.ops_seen && drain < DRAIN_LIMIT) begin
      @(negedge clk);
      drain++;
    end
    if (u_checker.checked < u_checker.ops_seen) begin
      $display("Timed out waiting for the last writeback");
      tb_errors++;
    end
    $display("Errors: %0d from checker, %0d from testbench", u_checker.errors, tb_errors);
    if (u_checker.errors + tb_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
mrv_pkg.sv
alu.sv
reg_file.sv
csr_file.sv
ex_stage.sv
ex_core.sv
ex_core_checker.sv
ex_core_assert.sv
tb_ex_core.sv
